// ==== dv/analog_assertions.sv ====
// concurrent checks on the DAC select and capture control, attached to dac_back and capture_fsm by bind
`timescale 1ns/1ps

module analog_assertions #(
  parameter bit DAC_SIDE = 1'b0  // set for the DAC instance, clear for the capture FSM
) (
  input logic                    adc_clk,
  input logic                    top_rst,
  input logic                    sel_i,    // DAC channel select
  input capture_pkg::cap_state_e state_i,  // capture state register
  input logic                    wr_en_i,  // buffer write enable
  input logic                    arm_i,    // arm strobe
  input logic                    done_i    // capture done level
);

  import capture_pkg::*;

  int unsigned fail_cnt = 0; // read back by the testbench

  if (DAC_SIDE) begin : g_dac
    // first edge out of reset only leaves reset, every later edge flips sel
    a_sel_toggle: assert property (@(posedge adc_clk) disable iff (top_rst)
      !$past(top_rst) |-> (sel_i != $past(sel_i)))
      else begin
        fail_cnt = fail_cnt + 1;
        $error("dac_sel_o held its value for a cycle");
      end
  end else begin : g_cap
    // buffer frozen once done
    a_no_write_done: assert property (@(posedge adc_clk) disable iff (top_rst)
      (state_i == CAP_DONE) |-> !wr_en_i)
      else begin
        fail_cnt = fail_cnt + 1;
        $error("write enable high in CAP_DONE");
      end

    // accepted arm clears done on the next cycle
    a_arm_clears_done: assert property (@(posedge adc_clk) disable iff (top_rst)
      (((state_i == CAP_IDLE) || (state_i == CAP_DONE)) && arm_i) |=> !done_i)
      else begin
        fail_cnt = fail_cnt + 1;
        $error("done_o still high after an accepted arm");
      end
  end

endmodule

bind dac_back analog_assertions #(.DAC_SIDE(1'b1)) u_dac_sva (
  .adc_clk (adc_clk),
  .top_rst (top_rst),
  .sel_i   (dac_sel_o),
  .state_i (capture_pkg::CAP_IDLE),
  .wr_en_i (1'b0),
  .arm_i   (1'b0),
  .done_i  (1'b0)
);

bind capture_fsm analog_assertions #(.DAC_SIDE(1'b0)) u_cap_sva (
  .adc_clk (adc_clk),
  .top_rst (top_rst),
  .sel_i   (1'b0),
  .state_i (state_q),
  .wr_en_i (ctl.wr_en),
  .arm_i   (arm_i),
  .done_i  (done_o)
);

// ==== dv/tb_analog_top.sv ====
// self-checking testbench for analog_top, compiled from list.f with tb_analog_top as top module
`timescale 1ns/1ps

module tb_analog_top;

  import analog_pkg::*;

  localparam int unsigned BUF_AW       = 5;
  localparam int unsigned POST_LEN     = 8;
  localparam int          DONE_TIMEOUT = 4 * POST_LEN + 16; // cycles
  localparam sample_t     LB_GEN_A     = sample_t'(6000);   // loopback inputs, A overflows
  localparam sample_t     LB_CTL_A     = sample_t'(5000);
  localparam sample_t     LB_GEN_B     = sample_t'(-300);
  localparam sample_t     LB_CTL_B     = sample_t'(120);

  logic              adc_clk;
  logic              top_rst;
  adc_raw_t          adc_dat_a, adc_dat_b;
  sample_t           gen_a, gen_b, ctl_a, ctl_b;
  logic              loop_en;
  dac_code_t         dac_dat;
  logic              dac_sel, dac_rst;
  logic              arm, trig, done;
  logic [BUF_AW-1:0] trig_ptr, rd_addr;
  sample_t           rd_dat_a, rd_dat_b;

  integer  seed;
  int      ramp_idx  = 0;    // index of the ramp word now on the ADC pins
  logic    dac_live  = 1'b0; // DAC register out of reset
  logic    exp_sel   = 1'b0; // channel select the DAC should show
  sample_t gen_a_q   = '0;   // inputs seen by the DAC register at the last edge
  sample_t gen_b_q   = '0;
  sample_t ctl_a_q   = '0;
  sample_t ctl_b_q   = '0;

  analog_top #(.BUF_AW(BUF_AW), .POST_LEN(POST_LEN)) uut (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .gen_a_i     (gen_a),
    .gen_b_i     (gen_b),
    .ctl_a_i     (ctl_a),
    .ctl_b_i     (ctl_b),
    .loop_i      (loop_en),
    .dac_dat_o   (dac_dat),
    .dac_sel_o   (dac_sel),
    .dac_rst_o   (dac_rst),
    .arm_i       (arm),
    .trig_i      (trig),
    .done_o      (done),
    .trig_ptr_o  (trig_ptr),
    .rd_addr_i   (rd_addr),
    .rd_dat_a_o  (rd_dat_a),
    .rd_dat_b_o  (rd_dat_b)
  );

  initial begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk; // 4 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // neg-slope code to two's complement, magnitude bits flip
  function automatic sample_t to_sample(adc_raw_t raw);
    logic [13:0] code;
    code = raw[15:2]; // reserved bits dropped
    return sample_t'(code ^ 14'h1fff);
  endfunction

  function automatic sample_t sat_sum(sample_t g, sample_t c);
    int s;
    s = int'(g) + int'(c);
    if (s > 8191) begin
      s = 8191;
    end else if (s < -8192) begin
      s = -8192;
    end
    return sample_t'(s);
  endfunction

  function automatic dac_code_t to_code(sample_t s);
    return dac_code_t'(s) ^ 14'h1fff;
  endfunction

  // ramps with changing reserved bits
  function automatic adc_raw_t ramp_raw_a(int k);
    return {14'(k * 37 + 5), 2'(k)};
  endfunction

  function automatic adc_raw_t ramp_raw_b(int k);
    return {14'(9000 - k * 53), 2'(k + 2)};
  endfunction

  function automatic int unsigned sva_failures();
    return uut.i_dac_back.u_dac_sva.fail_cnt + uut.i_capture_fsm.u_cap_sva.fail_cnt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checking and bus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_sim(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_sim($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // address out, data valid one edge later
  task automatic read_word(input logic [BUF_AW-1:0] addr, output sample_t a, output sample_t b);
    @(posedge adc_clk);
    rd_addr <= addr;
    @(posedge adc_clk);
    @(negedge adc_clk);
    a = rd_dat_a;
    b = rd_dat_b;
  endtask

  // arm, optional re-arm while armed, trigger, then wait for done
  task automatic run_capture(input bit arm_twice, output int trig_idx);
    int wait_cnt;
    @(posedge adc_clk);
    arm <= 1'b1;
    @(posedge adc_clk);
    arm <= 1'b0;
    @(negedge adc_clk);
    check("done_o", 32'(done), 32'd0); // cleared by the arm
    repeat (4) @(posedge adc_clk);
    if (arm_twice) begin
      arm <= 1'b1; // already armed, ignored
      @(posedge adc_clk);
      arm <= 1'b0;
    end
    @(posedge adc_clk);
    trig     <= 1'b1;
    trig_idx = ramp_idx; // raw word sampled on this edge
    @(posedge adc_clk);
    trig <= 1'b0;
    wait_cnt = 0;
    while (done != 1'b1) begin
      @(negedge adc_clk);
      wait_cnt++;
      if (wait_cnt > DONE_TIMEOUT) begin
        stop_sim("timeout, done_o never rose after the trigger");
      end
    end
    check("done_o latency", 32'(wait_cnt), 32'(POST_LEN + 1)); // trigger word + POST_LEN
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // free running ADC ramp and the DAC comparator
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge adc_clk) begin
    adc_dat_a <= ramp_raw_a(ramp_idx + 1);
    adc_dat_b <= ramp_raw_b(ramp_idx + 1);
    ramp_idx  <= ramp_idx + 1;
  end

  always @(posedge adc_clk) begin
    gen_a_q <= gen_a;
    gen_b_q <= gen_b;
    ctl_a_q <= ctl_a;
    ctl_b_q <= ctl_b;
  end

  always @(negedge adc_clk) begin
    if (dac_live) begin
      exp_sel = ~exp_sel; // flipped at the last edge
      check("dac_sel_o", 32'(dac_sel), 32'(exp_sel));
      if (exp_sel) begin
        check("dac_dat_o (A)", 32'(dac_dat), 32'(to_code(sat_sum(gen_a_q, ctl_a_q))));
      end else begin
        check("dac_dat_o (B)", 32'(dac_dat), 32'(to_code(sat_sum(gen_b_q, ctl_b_q))));
      end
    end
    if (sva_failures() != 0) begin
      stop_sim("a bound assertion failed");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int                trig_idx;
    logic [BUF_AW-1:0] addr;
    sample_t           rd_a;
    sample_t           rd_b;
    seed      = 32'h2af;
    top_rst   = 1'b1;
    adc_dat_a = ramp_raw_a(0);
    adc_dat_b = ramp_raw_b(0);
    gen_a     = '0;
    gen_b     = '0;
    ctl_a     = '0;
    ctl_b     = '0;
    loop_en   = 1'b0;
    arm       = 1'b0;
    trig      = 1'b0;
    rd_addr   = '0;

    // reset, 2 cycles
    @(posedge adc_clk);
    @(negedge adc_clk);
    check("dac_rst_o", 32'(dac_rst), 32'd1);
    check("dac_sel_o", 32'(dac_sel), 32'd0);
    check("dac_dat_o", 32'(dac_dat), 32'd0);
    check("done_o", 32'(done), 32'd0);
    @(posedge adc_clk);
    top_rst <= 1'b0;
    @(negedge adc_clk);
    check("dac_rst_o", 32'(dac_rst), 32'd1); // falls one edge later
    check("dac_sel_o", 32'(dac_sel), 32'd0);
    check("dac_dat_o", 32'(dac_dat), 32'd0);
    @(posedge adc_clk);
    dac_live <= 1'b1;
    @(negedge adc_clk);
    check("dac_rst_o", 32'(dac_rst), 32'd0);

    // trigger while idle, nothing happens
    @(posedge adc_clk);
    trig <= 1'b1;
    @(posedge adc_clk);
    trig <= 1'b0;
    repeat (POST_LEN + 4) @(posedge adc_clk);
    @(negedge adc_clk);
    check("done_o", 32'(done), 32'd0);

    // DAC sums, first two sets overflow both ways
    for (int n = 0; n < 12; n++) begin
      @(posedge adc_clk);
      case (n)
        0: begin
          gen_a <= sample_t'(8000);
          ctl_a <= sample_t'(1000);
          gen_b <= sample_t'(-8000);
          ctl_b <= sample_t'(-1000);
        end
        1: begin
          gen_a <= sample_t'(-8192);
          ctl_a <= sample_t'(-8192);
          gen_b <= sample_t'(8191);
          ctl_b <= sample_t'(8191);
        end
        default: begin
          gen_a <= sample_t'($random(seed));
          ctl_a <= sample_t'($random(seed));
          gen_b <= sample_t'($random(seed));
          ctl_b <= sample_t'($random(seed));
        end
      endcase
      repeat (3) @(posedge adc_clk); // held 4 cycles
    end

    // ADC ramp capture with a second arm while armed
    run_capture(1'b1, trig_idx);
    addr = trig_ptr;
    for (int j = 0; j <= int'(POST_LEN); j++) begin
      read_word(addr, rd_a, rd_b);
      check("rd_dat_a_o", 32'(rd_a), 32'(to_sample(ramp_raw_a(trig_idx + j))));
      check("rd_dat_b_o", 32'(rd_b), 32'(to_sample(ramp_raw_b(trig_idx + j))));
      addr = addr + 1'b1; // wraps with the buffer
    end

    // loopback capture, re-armed from CAP_DONE
    @(posedge adc_clk);
    loop_en <= 1'b1;
    gen_a   <= LB_GEN_A;
    ctl_a   <= LB_CTL_A;
    gen_b   <= LB_GEN_B;
    ctl_b   <= LB_CTL_B;
    run_capture(1'b0, trig_idx);
    addr = trig_ptr;
    for (int j = 0; j <= int'(POST_LEN); j++) begin
      read_word(addr, rd_a, rd_b);
      check("rd_dat_a_o", 32'(rd_a), 32'(sat_sum(LB_GEN_A, LB_CTL_A)));
      check("rd_dat_b_o", 32'(rd_b), 32'(sat_sum(LB_GEN_B, LB_CTL_B)));
      addr = addr + 1'b1;
    end

    repeat (2) @(posedge adc_clk);
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== list.f ====
rtl/analog_pkg.sv
rtl/capture_pkg.sv
rtl/capture_ctl_if.sv
rtl/adc_front.sv
rtl/dac_back.sv
rtl/capture_fsm.sv
rtl/capture_counter.sv
rtl/capture_buffer.sv
rtl/analog_top.sv
dv/analog_assertions.sv
dv/tb_analog_top.sv

// ==== rtl/adc_front.sv ====
// ADC input stage: registers raw words, converts to two's complement, muxes in the DAC loopback
`timescale 1ns/1ps

module adc_front (
  input  logic                 adc_clk,
  input  logic                 top_rst,
  input  analog_pkg::adc_raw_t adc_dat_a_i, // raw ADC channel A
  input  analog_pkg::adc_raw_t adc_dat_b_i, // raw ADC channel B
  input  logic                 loop_i,      // digital loopback enable
  input  analog_pkg::sample_t  sat_a_i,     // saturated DAC sample A
  input  analog_pkg::sample_t  sat_b_i,     // saturated DAC sample B
  output analog_pkg::sample_t  adc_a_o,
  output analog_pkg::sample_t  adc_b_o
);

  import analog_pkg::*;

  adc_raw_t raw   [CH_N]; // per channel views of the pins
  sample_t  adc_q [CH_N]; // converted, registered
  sample_t  sat   [CH_N];

  assign raw[0] = adc_dat_a_i;
  assign raw[1] = adc_dat_b_i;
  assign sat[0] = sat_a_i;
  assign sat[1] = sat_b_i;

  for (genvar i = 0; i < CH_N; i++) begin : g_ch
    // input register, drop the two reserved bits
    // neg-slope offset binary -> two's complement: keep msb, flip the rest
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        adc_q[i] <= '0;
      end else begin
        adc_q[i] <= {raw[i][RAW_W-1], ~raw[i][RAW_W-2:RAW_W-SAMPLE_W]};
      end
    end
  end

  // loopback mux, combinational so DAC value shows up the same cycle
  assign adc_a_o = loop_i ? sat[0] : adc_q[0];
  assign adc_b_o = loop_i ? sat[1] : adc_q[1];

endmodule

// ==== rtl/analog_pkg.sv ====
// sample, sum and DAC code types for the ADC/DAC data path, imported by the data modules
package analog_pkg;

  // converter widths
  localparam int unsigned SAMPLE_W = 14;          // signed sample width
  localparam int unsigned RAW_W    = 16;          // raw ADC bus width
  localparam int unsigned SUM_W    = SAMPLE_W + 1; // one guard bit for gen + ctl

  // raw ADC word, bits [1:0] reserved and dropped
  typedef logic [RAW_W-1:0] adc_raw_t;

  // two's complement sample (ADC, generator, controller, saturated DAC)
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // sum of generator and controller before saturation
  typedef logic signed [SUM_W-1:0] dac_sum_t;

  // offset-binary code word with negative slope, as the DAC expects it
  typedef logic [SAMPLE_W-1:0] dac_code_t;

  // number of analog channels on the board
  localparam int unsigned CH_N = 2;

endpackage

// ==== rtl/analog_top.sv ====
// top level of the analog data path: ADC front end, DAC back end and triggered capture
`timescale 1ns/1ps

module analog_top #(
  parameter int unsigned BUF_AW   = 5, // capture buffer address width
  parameter int unsigned POST_LEN = 8  // post-trigger words, below buffer depth
) (
  input  logic                  adc_clk,
  input  logic                  top_rst,     // async, active high
  // ADC
  input  analog_pkg::adc_raw_t  adc_dat_a_i,
  input  analog_pkg::adc_raw_t  adc_dat_b_i,
  // generator and controller samples
  input  analog_pkg::sample_t   gen_a_i,
  input  analog_pkg::sample_t   gen_b_i,
  input  analog_pkg::sample_t   ctl_a_i,
  input  analog_pkg::sample_t   ctl_b_i,
  input  logic                  loop_i,      // digital loopback
  // DAC
  output analog_pkg::dac_code_t dac_dat_o,   // combined data
  output logic                  dac_sel_o,   // channel select
  output logic                  dac_rst_o,   // DAC reset
  // capture
  input  logic                  arm_i,
  input  logic                  trig_i,
  output logic                  done_o,
  output logic [BUF_AW-1:0]     trig_ptr_o,
  input  logic [BUF_AW-1:0]     rd_addr_i,
  output analog_pkg::sample_t   rd_dat_a_o,
  output analog_pkg::sample_t   rd_dat_b_o
);

  import analog_pkg::*;

  sample_t sat_a, sat_b; // saturated DAC values, loopback source
  sample_t adc_a, adc_b; // converted ADC (or loopback) samples

  ////////////////////////////////////////////////////////////////////////////
  // converters
  ////////////////////////////////////////////////////////////////////////////

  adc_front i_adc_front (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_i      (loop_i),
    .sat_a_i     (sat_a),
    .sat_b_i     (sat_b),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b)
  );

  dac_back i_dac_back (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .gen_a_i   (gen_a_i),
    .gen_b_i   (gen_b_i),
    .ctl_a_i   (ctl_a_i),
    .ctl_b_i   (ctl_b_i),
    .sat_a_o   (sat_a),
    .sat_b_o   (sat_b),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_rst_o (dac_rst_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // capture
  ////////////////////////////////////////////////////////////////////////////

  capture_ctl_if #(.BUF_AW(BUF_AW)) cap_ctl ();

  capture_fsm #(.BUF_AW(BUF_AW)) i_capture_fsm (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .arm_i      (arm_i),
    .trig_i     (trig_i),
    .ctl        (cap_ctl.fsm),
    .done_o     (done_o),
    .trig_ptr_o (trig_ptr_o)
  );

  capture_counter #(
    .BUF_AW   (BUF_AW),
    .POST_LEN (POST_LEN)
  ) i_capture_counter (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .ctl     (cap_ctl.counter)
  );

  capture_buffer #(.BUF_AW(BUF_AW)) i_capture_buffer (
    .adc_clk    (adc_clk),
    .ctl        (cap_ctl.buffer),
    .adc_a_i    (adc_a),      // CH 1
    .adc_b_i    (adc_b),      // CH 2
    .rd_addr_i  (rd_addr_i),
    .rd_dat_a_o (rd_dat_a_o),
    .rd_dat_b_o (rd_dat_b_o)
  );

endmodule

// ==== rtl/capture_buffer.sv ====
// two-channel circular sample memory, written from the capture control, read back by address
`timescale 1ns/1ps

module capture_buffer #(
  parameter int unsigned BUF_AW = 5 // depth is 2**BUF_AW words
) (
  input  logic                adc_clk,
  capture_ctl_if.buffer       ctl,
  input  analog_pkg::sample_t adc_a_i,     // channel A sample
  input  analog_pkg::sample_t adc_b_i,     // channel B sample
  input  logic [BUF_AW-1:0]   rd_addr_i,   // read address
  output analog_pkg::sample_t rd_dat_a_o,  // 1 cycle after rd_addr_i
  output analog_pkg::sample_t rd_dat_b_o
);

  import capture_pkg::*;

  localparam int unsigned DEPTH = 2 ** BUF_AW;

  cap_word_t mem [DEPTH]; // plain RAM, no reset
  cap_word_t wr_word;
  cap_word_t rd_q;

  assign wr_word.a = adc_a_i;
  assign wr_word.b = adc_b_i;

  // write port
  always_ff @(posedge adc_clk) begin
    if (ctl.wr_en) begin
      mem[ctl.wr_ptr] <= wr_word;
    end
  end

  // registered read port, maps onto block RAM
  always_ff @(posedge adc_clk) begin
    rd_q <= mem[rd_addr_i];
  end

  assign rd_dat_a_o = rd_q.a;
  assign rd_dat_b_o = rd_q.b;

endmodule

// ==== rtl/capture_counter.sv ====
// capture write pointer and post-trigger down-counter, driven from the capture control bundle
`timescale 1ns/1ps

module capture_counter #(
  parameter int unsigned BUF_AW   = 5, // buffer address width
  parameter int unsigned POST_LEN = 8  // words after the trigger word
) (
  input  logic          adc_clk,
  input  logic          top_rst,
  capture_ctl_if.counter ctl
);

  // POST_LEN < depth, so the address width is enough for the counter
  localparam logic [BUF_AW-1:0] CNT_INIT = BUF_AW'(POST_LEN);
  localparam logic [BUF_AW-1:0] CNT_LAST = BUF_AW'(1);

  logic [BUF_AW-1:0] ptr_q;
  logic [BUF_AW-1:0] cnt_q; // words still to write after trigger

  // circular pointer, power of two depth wraps on its own
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      ptr_q <= '0;
    end else if (ctl.wr_en) begin
      ptr_q <= ptr_q + 1'b1;
    end
  end

  // load on trigger, count post writes down to zero
  // stays at zero while armed so post_done cannot fire early
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cnt_q <= '0;
    end else if (ctl.post_load) begin
      cnt_q <= CNT_INIT;
    end else if (ctl.wr_en && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign ctl.wr_ptr    = ptr_q;
  assign ctl.post_done = ctl.wr_en && (cnt_q == CNT_LAST); // last post write

endmodule

// ==== rtl/capture_ctl_if.sv ====
// write control bundle shared by the capture FSM, counter and buffer inside the capture path
`timescale 1ns/1ps

interface capture_ctl_if #(
  parameter int unsigned BUF_AW = 5  // buffer address width
) ();

  logic              wr_en;     // write one word this cycle
  logic              post_load; // trigger accepted, load post counter
  logic [BUF_AW-1:0] wr_ptr;    // current write address
  logic              post_done; // last post-trigger write

  // state machine side
  modport fsm (
    output wr_en,
    output post_load,
    input  post_done,
    input  wr_ptr     // trigger address is latched from here
  );

  // pointer and down-counter
  modport counter (
    input  wr_en,
    input  post_load,
    output wr_ptr,
    output post_done
  );

  // sample memory, write side only
  modport buffer (
    input  wr_en,
    input  wr_ptr
  );

endinterface

// ==== rtl/capture_fsm.sv ====
// capture sequencer: arm, trigger, post-trigger fill and done, drives the buffer write control
`timescale 1ns/1ps

module capture_fsm #(
  parameter int unsigned BUF_AW = 5        // width of the latched trigger address
) (
  input  logic              adc_clk,
  input  logic              top_rst,
  input  logic              arm_i,         // start a new capture
  input  logic              trig_i,        // trigger strobe
  capture_ctl_if.fsm        ctl,
  output logic              done_o,        // capture complete
  output logic [BUF_AW-1:0] trig_ptr_o     // address of the trigger word
);

  import capture_pkg::*;

  cap_state_e        state_q, state_d;
  logic [BUF_AW-1:0] trig_ptr_q;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      CAP_IDLE, CAP_DONE: if (arm_i)         state_d = CAP_ARMED;
      CAP_ARMED:          if (trig_i)        state_d = CAP_POST;
      CAP_POST:           if (ctl.post_done) state_d = CAP_DONE;
      default:                               state_d = CAP_IDLE;
    endcase
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      state_q <= CAP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // write while armed and through the post-trigger run
  assign ctl.wr_en     = (state_q == CAP_ARMED) || (state_q == CAP_POST);
  assign ctl.post_load = (state_q == CAP_ARMED) && trig_i; // one cycle only

  // trigger word goes to the current wr_ptr, keep its address
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      trig_ptr_q <= '0;
    end else if (ctl.post_load) begin
      trig_ptr_q <= ctl.wr_ptr;
    end
  end

  assign trig_ptr_o = trig_ptr_q;
  assign done_o     = (state_q == CAP_DONE); // drops as soon as re-armed

endmodule

// ==== rtl/capture_pkg.sv ====
// capture state encoding and buffer word type, imported by the capture blocks
package capture_pkg;

  // capture sequence
  //   idle  -> waiting for arm
  //   armed -> writing continuously, waiting for trigger
  //   post  -> writing the post-trigger samples
  //   done  -> buffer frozen, can be read back
  typedef enum logic [1:0] {
    CAP_IDLE  = 2'd0,
    CAP_ARMED = 2'd1,
    CAP_POST  = 2'd2,
    CAP_DONE  = 2'd3
  } cap_state_e;

  // one buffer word holds both channels, A on top
  typedef struct packed {
    analog_pkg::sample_t a; // channel A
    analog_pkg::sample_t b; // channel B
  } cap_word_t;

endpackage

// ==== rtl/dac_back.sv ====
// DAC output stage: sums generator and controller, saturates, converts and interleaves channels
`timescale 1ns/1ps

module dac_back (
  input  logic                  adc_clk,
  input  logic                  top_rst,
  input  analog_pkg::sample_t   gen_a_i,   // generator A
  input  analog_pkg::sample_t   gen_b_i,   // generator B
  input  analog_pkg::sample_t   ctl_a_i,   // controller A
  input  analog_pkg::sample_t   ctl_b_i,   // controller B
  output analog_pkg::sample_t   sat_a_o,   // saturated A, to loopback
  output analog_pkg::sample_t   sat_b_o,   // saturated B, to loopback
  output analog_pkg::dac_code_t dac_dat_o, // interleaved DAC bus
  output logic                  dac_sel_o, // 1 -> A on bus, 0 -> B
  output logic                  dac_rst_o  // DAC reset
);

  import analog_pkg::*;

  sample_t   gen  [CH_N];
  sample_t   ctl  [CH_N];
  dac_sum_t  sum  [CH_N]; // 15 bit, cannot overflow
  sample_t   sat  [CH_N];
  dac_code_t code [CH_N];
  logic      sel_q;

  assign gen[0] = gen_a_i;
  assign gen[1] = gen_b_i;
  assign ctl[0] = ctl_a_i;
  assign ctl[1] = ctl_b_i;

  ////////////////////////////////////////////////////////////////////////////
  // per channel sum, saturation and code conversion
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < CH_N; i++) begin : g_ch
    assign sum[i] = gen[i] + ctl[i]; // both sign extended to 15 bits

    // top two bits differ -> out of range, clamp toward the sign
    assign sat[i] = (^sum[i][SUM_W-1 -: 2])
                  ? {sum[i][SUM_W-1], {(SAMPLE_W-1){~sum[i][SUM_W-1]}}}
                  : sum[i][SAMPLE_W-1:0];

    // back to neg-slope offset binary
    assign code[i] = {sat[i][SAMPLE_W-1], ~sat[i][SAMPLE_W-2:0]};
  end

  assign sat_a_o = sat[0];
  assign sat_b_o = sat[1];

  ////////////////////////////////////////////////////////////////////////////
  // interleaved output register
  ////////////////////////////////////////////////////////////////////////////

  // sel flips every edge, data follows the new sel value
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sel_q     <= 1'b0;
      dac_dat_o <= '0;
    end else begin
      sel_q     <= ~sel_q;
      dac_dat_o <= sel_q ? code[1] : code[0]; // new sel 1 -> A
    end
  end

  assign dac_sel_o = sel_q;

  // DAC held in reset, released one edge after top_rst drops
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_rst_o <= 1'b1;
    end else begin
      dac_rst_o <= 1'b0;
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the analog_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f list.f \
  --top-module tb_analog_top \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
